// ==== rtl/game_pkg.sv ====
package game_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shared vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Wide enough for the counters of an 800x600 frame including porches
    typedef logic [10:0] coord_t;

    // Packed as red, green, blue with four bits each
    typedef logic [11:0] rgb_t;

    // Vertical motion of the hero
    typedef enum logic [1:0] {
        ON_GROUND = 2'd0,
        RISING    = 2'd1,
        FALLING   = 2'd2
    } move_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Palette
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam rgb_t COLOR_SKY   = 12'h8_C_F;
    localparam rgb_t COLOR_FLOOR = 12'h6_4_2;
    localparam rgb_t COLOR_CHAR  = 12'hF_0_0;
    localparam rgb_t COLOR_PLAT  = 12'h0_A_0;
    localparam rgb_t COLOR_BLANK = 12'h0_0_0;

endpackage

// ==== rtl/vga_timing.sv ====
`timescale 1ns/10ps

module vga_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BACK   = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BACK   = 23
) (
    input  logic             clk,
    input  logic             rst_n,
    output game_pkg::coord_t hcount,
    output game_pkg::coord_t vcount,
    output logic             hsync,
    output logic             vsync,
    output logic             hblnk,
    output logic             vblnk,
    output logic             frame_start
);

    import game_pkg::*;

    localparam coord_t H_LAST     = coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam coord_t V_LAST     = coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
    localparam coord_t H_SYNC_BEG = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t H_SYNC_END = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t V_SYNC_BEG = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t V_SYNC_END = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam coord_t H_VIS      = coord_t'(H_ACTIVE);
    localparam coord_t V_VIS      = coord_t'(V_ACTIVE);

    logic line_end;
    logic frame_end;

    assign line_end  = (hcount == H_LAST);
    assign frame_end = line_end && (vcount == V_LAST);

    // The frame pulse is registered so that it lines up with the counters at 0,0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount      <= '0;
            vcount      <= '0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= frame_end;
            if (line_end) begin
                hcount <= '0;
                if (vcount == V_LAST) begin
                    vcount <= '0;
                end else begin
                    vcount <= vcount + coord_t'(1);
                end
            end else begin
                hcount <= hcount + coord_t'(1);
            end
        end
    end

    // Sync pulses are active low
    assign hsync = !((hcount >= H_SYNC_BEG) && (hcount < H_SYNC_END));
    assign vsync = !((vcount >= V_SYNC_BEG) && (vcount < V_SYNC_END));
    assign hblnk = (hcount >= H_VIS);
    assign vblnk = (vcount >= V_VIS);

    // The controller relies on this pulse marking the very first pixel
    assert property (@(posedge clk) disable iff (!rst_n)
        frame_start |-> (hcount == '0) && (vcount == '0));

endmodule

// ==== rtl/draw_bg.sv ====
`timescale 1ns/10ps

module draw_bg #(
    parameter int V_ACTIVE = 600,
    parameter int FLOOR_H  = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  game_pkg::coord_t hcount_in,
    input  game_pkg::coord_t vcount_in,
    input  logic             hsync_in,
    input  logic             vsync_in,
    input  logic             hblnk_in,
    input  logic             vblnk_in,
    output game_pkg::coord_t hcount,
    output game_pkg::coord_t vcount,
    output logic             hsync,
    output logic             vsync,
    output logic             blank,
    output game_pkg::rgb_t   rgb
);

    import game_pkg::*;

    // First row of the floor band
    localparam coord_t FLOOR_LINE = coord_t'(V_ACTIVE - FLOOR_H);

    logic blank_nxt;
    rgb_t rgb_nxt;

    assign blank_nxt = hblnk_in || vblnk_in;

    always_comb begin
        if (blank_nxt) begin
            rgb_nxt = COLOR_BLANK;
        end else if (vcount_in >= FLOOR_LINE) begin
            rgb_nxt = COLOR_FLOOR;
        end else begin
            rgb_nxt = COLOR_SKY;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            blank  <= 1'b1;
            rgb    <= COLOR_BLANK;
        end else begin
            hcount <= hcount_in;
            vcount <= vcount_in;
            hsync  <= hsync_in;
            vsync  <= vsync_in;
            blank  <= blank_nxt;
            rgb    <= rgb_nxt;
        end
    end

endmodule

// ==== rtl/char_ctrl.sv ====
`timescale 1ns/10ps

module char_ctrl #(
    parameter int H_ACTIVE    = 800,
    parameter int V_ACTIVE    = 600,
    parameter int FLOOR_H     = 4,
    parameter int CHAR_SIZE   = 32,
    parameter int START_X     = 100,
    parameter int JUMP_FRAMES = 60
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             frame_start,
    input  logic             step_left,
    input  logic             step_right,
    input  logic             step_jump,
    input  logic             on_ground,
    output game_pkg::coord_t pos_x,
    output game_pkg::coord_t pos_y
);

    import game_pkg::*;

    localparam int     CNT_W   = $clog2(JUMP_FRAMES + 1);
    localparam coord_t X_MAX   = coord_t'(H_ACTIVE - CHAR_SIZE);
    localparam coord_t Y_FLOOR = coord_t'(V_ACTIVE - FLOOR_H - CHAR_SIZE);

    move_state_t            state;
    logic [CNT_W-1:0]       jump_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Horizontal walk by one pixel per frame with clamping at both edges
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos_x <= coord_t'(START_X);
        end else if (frame_start) begin
            if (step_left && !step_right && (pos_x != '0)) begin
                pos_x <= pos_x - coord_t'(1);
            end else if (step_right && !step_left && (pos_x < X_MAX)) begin
                pos_x <= pos_x + coord_t'(1);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vertical motion FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ON_GROUND;
            jump_cnt <= '0;
            pos_y    <= Y_FLOOR;
        end else if (frame_start) begin
            case (state)
                ON_GROUND: begin
                    if (!on_ground) begin
                        // Walked off an edge
                        state <= FALLING;
                    end else if (step_jump) begin
                        // The take-off frame already counts as the first rise step
                        pos_y    <= pos_y - coord_t'(1);
                        jump_cnt <= CNT_W'(1);
                        state    <= (JUMP_FRAMES == 1) ? FALLING : RISING;
                    end
                end
                RISING: begin
                    pos_y    <= pos_y - coord_t'(1);
                    jump_cnt <= jump_cnt + CNT_W'(1);
                    if ((jump_cnt + CNT_W'(1) == CNT_W'(JUMP_FRAMES)) ||
                        (pos_y == coord_t'(1))) begin
                        state <= FALLING;
                    end
                end
                FALLING: begin
                    if (on_ground) begin
                        state <= ON_GROUND;
                    end else begin
                        pos_y <= pos_y + coord_t'(1);
                    end
                end
                default: begin
                    state <= FALLING;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        pos_x <= X_MAX);

    // The floor support keeps a falling hero from sinking into the floor band
    assert property (@(posedge clk) disable iff (!rst_n)
        pos_y <= Y_FLOOR);

endmodule

// ==== rtl/draw_char.sv ====
`timescale 1ns/10ps

module draw_char #(
    parameter int CHAR_SIZE = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  game_pkg::coord_t hcount_in,
    input  game_pkg::coord_t vcount_in,
    input  logic             hsync_in,
    input  logic             vsync_in,
    input  logic             blank_in,
    input  game_pkg::rgb_t   rgb_in,
    input  game_pkg::coord_t pos_x,
    input  game_pkg::coord_t pos_y,
    output game_pkg::coord_t hcount,
    output game_pkg::coord_t vcount,
    output logic             hsync,
    output logic             vsync,
    output logic             blank,
    output game_pkg::rgb_t   rgb
);

    import game_pkg::*;

    localparam coord_t SIZE = coord_t'(CHAR_SIZE);

    logic in_col;
    logic in_row;
    logic hero_px;

    assign in_col  = (hcount_in >= pos_x) && (hcount_in < pos_x + SIZE);
    assign in_row  = (vcount_in >= pos_y) && (vcount_in < pos_y + SIZE);
    assign hero_px = in_col && in_row && !blank_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            blank  <= 1'b1;
            rgb    <= COLOR_BLANK;
        end else begin
            hcount <= hcount_in;
            vcount <= vcount_in;
            hsync  <= hsync_in;
            vsync  <= vsync_in;
            blank  <= blank_in;
            rgb    <= hero_px ? COLOR_CHAR : rgb_in;
        end
    end

endmodule

// ==== rtl/platform_layer.sv ====
`timescale 1ns/10ps

module platform_layer #(
    parameter int V_ACTIVE  = 600,
    parameter int FLOOR_H   = 4,
    parameter int CHAR_SIZE = 32,
    parameter int PLAT_X    = 300,
    parameter int PLAT_W    = 200,
    parameter int PLAT_Y    = 450
) (
    input  logic             clk,
    input  logic             rst_n,
    input  game_pkg::coord_t hcount_in,
    input  game_pkg::coord_t vcount_in,
    input  logic             hsync_in,
    input  logic             vsync_in,
    input  logic             blank_in,
    input  game_pkg::rgb_t   rgb_in,
    input  game_pkg::coord_t pos_x,
    input  game_pkg::coord_t pos_y,
    output game_pkg::coord_t hcount,
    output game_pkg::coord_t vcount,
    output logic             hsync,
    output logic             vsync,
    output logic             blank,
    output game_pkg::rgb_t   rgb,
    output logic             on_ground
);

    import game_pkg::*;

    localparam coord_t SIZE       = coord_t'(CHAR_SIZE);
    localparam coord_t FLOOR_LINE = coord_t'(V_ACTIVE - FLOOR_H);
    localparam coord_t P_LEFT     = coord_t'(PLAT_X);
    localparam coord_t P_END      = coord_t'(PLAT_X + PLAT_W);
    localparam coord_t P_ROW      = coord_t'(PLAT_Y);

    coord_t bottom;
    logic   overlap;
    logic   plat_px;

    // The hero stands when its bottom edge touches a surface
    assign bottom    = pos_y + SIZE;
    assign overlap   = (pos_x + SIZE > P_LEFT) && (pos_x < P_END);
    assign on_ground = (bottom == FLOOR_LINE) || ((bottom == P_ROW) && overlap);

    // The platform is a single row drawn on top of the hero
    assign plat_px = (vcount_in == P_ROW) && (hcount_in >= P_LEFT) &&
                     (hcount_in < P_END) && !blank_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            blank  <= 1'b1;
            rgb    <= COLOR_BLANK;
        end else begin
            hcount <= hcount_in;
            vcount <= vcount_in;
            hsync  <= hsync_in;
            vsync  <= vsync_in;
            blank  <= blank_in;
            rgb    <= plat_px ? COLOR_PLAT : rgb_in;
        end
    end

endmodule

// ==== rtl/top_vga.sv ====
`timescale 1ns/10ps

module top_vga #(
    parameter int H_ACTIVE    = 800,
    parameter int H_FRONT     = 40,
    parameter int H_SYNC      = 128,
    parameter int H_BACK      = 88,
    parameter int V_ACTIVE    = 600,
    parameter int V_FRONT     = 1,
    parameter int V_SYNC      = 4,
    parameter int V_BACK      = 23,
    parameter int FLOOR_H     = 4,
    parameter int CHAR_SIZE   = 32,
    parameter int START_X     = 100,
    parameter int JUMP_FRAMES = 60,
    parameter int PLAT_X      = 300,
    parameter int PLAT_W      = 200,
    parameter int PLAT_Y      = 450
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           step_left,
    input  logic           step_right,
    input  logic           step_jump,
    output logic           hs,
    output logic           vs,
    output game_pkg::rgb_t rgb
);

    import game_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage signals
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    coord_t hcount_tim, vcount_tim;
    logic   hsync_tim, vsync_tim, hblnk_tim, vblnk_tim;
    logic   frame_start;

    coord_t hcount_bg, vcount_bg;
    logic   hsync_bg, vsync_bg, blank_bg;
    rgb_t   rgb_bg;

    coord_t hcount_ch, vcount_ch;
    logic   hsync_ch, vsync_ch, blank_ch;
    rgb_t   rgb_ch;

    coord_t pos_x, pos_y;
    logic   on_ground;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) u_vga_timing (
        .clk, .rst_n,
        .hcount (hcount_tim), .vcount (vcount_tim),
        .hsync  (hsync_tim),  .vsync  (vsync_tim),
        .hblnk  (hblnk_tim),  .vblnk  (vblnk_tim),
        .frame_start
    );

    draw_bg #(.V_ACTIVE (V_ACTIVE), .FLOOR_H (FLOOR_H)) u_draw_bg (
        .clk, .rst_n,
        .hcount_in (hcount_tim), .vcount_in (vcount_tim),
        .hsync_in  (hsync_tim),  .vsync_in  (vsync_tim),
        .hblnk_in  (hblnk_tim),  .vblnk_in  (vblnk_tim),
        .hcount (hcount_bg), .vcount (vcount_bg), .hsync (hsync_bg),
        .vsync  (vsync_bg),  .blank  (blank_bg),  .rgb   (rgb_bg)
    );

    char_ctrl #(
        .H_ACTIVE (H_ACTIVE), .V_ACTIVE (V_ACTIVE), .FLOOR_H (FLOOR_H),
        .CHAR_SIZE (CHAR_SIZE), .START_X (START_X), .JUMP_FRAMES (JUMP_FRAMES)
    ) u_char_ctrl (
        .clk, .rst_n, .frame_start,
        .step_left, .step_right, .step_jump, .on_ground,
        .pos_x, .pos_y
    );

    draw_char #(.CHAR_SIZE (CHAR_SIZE)) u_draw_char (
        .clk, .rst_n,
        .hcount_in (hcount_bg), .vcount_in (vcount_bg), .hsync_in (hsync_bg),
        .vsync_in  (vsync_bg),  .blank_in  (blank_bg),  .rgb_in   (rgb_bg),
        .pos_x, .pos_y,
        .hcount (hcount_ch), .vcount (vcount_ch), .hsync (hsync_ch),
        .vsync  (vsync_ch),  .blank  (blank_ch),  .rgb   (rgb_ch)
    );

    // Only sync and colour of the last stage leave the chip
    platform_layer #(
        .V_ACTIVE (V_ACTIVE), .FLOOR_H (FLOOR_H), .CHAR_SIZE (CHAR_SIZE),
        .PLAT_X (PLAT_X), .PLAT_W (PLAT_W), .PLAT_Y (PLAT_Y)
    ) u_platform_layer (
        .clk, .rst_n,
        .hcount_in (hcount_ch), .vcount_in (vcount_ch), .hsync_in (hsync_ch),
        .vsync_in  (vsync_ch),  .blank_in  (blank_ch),  .rgb_in   (rgb_ch),
        .pos_x, .pos_y,
        .hcount (), .vcount (), .hsync (hs), .vsync (vs), .blank (), .rgb,
        .on_ground
    );

endmodule

// ==== test/top_vga_tb.sv ====
`timescale 1ns/10ps

module top_vga_tb;

    import game_pkg::*;

    // Tiny 32x24 screen with two-pixel porches and syncs
    localparam int H_ACTIVE    = 32;
    localparam int H_FRONT     = 2;
    localparam int H_SYNC      = 2;
    localparam int H_BACK      = 2;
    localparam int V_ACTIVE    = 24;
    localparam int V_FRONT     = 2;
    localparam int V_SYNC      = 2;
    localparam int V_BACK      = 2;
    // A four-row floor band puts the jump apex level with the platform row
    localparam int FLOOR_H     = 4;
    localparam int CHAR_SIZE   = 3;
    localparam int START_X     = 2;
    localparam int JUMP_FRAMES = 6;
    localparam int PLAT_X      = 16;
    localparam int PLAT_W      = 10;
    localparam int PLAT_Y      = 14;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int LATENCY      = 3;
    localparam int REC_WORDS    = 7;
    localparam int MAX_RECS     = 24;

    logic clk;
    logic rst_n;
    logic step_left;
    logic step_right;
    logic step_jump;
    logic hs;
    logic vs;
    rgb_t rgb;

    logic [7:0] tdata [0:REC_WORDS*MAX_RECS-1];
    rgb_t       frame_buf [0:H_ACTIVE*V_ACTIVE-1];
    event       vs_fall_ev;

    int test_no;
    int cycle;
    int limit;
    int vs_last;
    int rec;
    int base;
    int total_frames;
    int oi;
    int oh;
    int ov;
    int exp_hs;
    int exp_vs;

    top_vga #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK),
        .FLOOR_H (FLOOR_H), .CHAR_SIZE (CHAR_SIZE), .START_X (START_X),
        .JUMP_FRAMES (JUMP_FRAMES), .PLAT_X (PLAT_X), .PLAT_W (PLAT_W), .PLAT_Y (PLAT_Y)
    ) dut (
        .clk, .rst_n, .step_left, .step_right, .step_jump, .hs, .vs, .rgb
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting and expected scene
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            stop_run($sformatf("CHECK FAILED test %0d %s: expected 'h%0h, actual 'h%0h",
                               test_no, what, expected, actual));
        end
    endtask

    // The platform row wins over the hero and the hero wins over sky and floor
    function automatic rgb_t scene_colour(input int h, input int v, input int hx, input int hy);
        rgb_t c;
        if (v == PLAT_Y && h >= PLAT_X && h < PLAT_X + PLAT_W) begin
            c = COLOR_PLAT;
        end else if (h >= hx && h < hx + CHAR_SIZE && v >= hy && v < hy + CHAR_SIZE) begin
            c = COLOR_CHAR;
        end else if (v >= V_ACTIVE - FLOOR_H) begin
            c = COLOR_FLOOR;
        end else begin
            c = COLOR_SKY;
        end
        return c;
    endfunction

    task automatic check_frame(input int exp_x, input int exp_y);
        int hero_x;
        int hero_y;
        int idx;
        hero_x = -1;
        hero_y = -1;
        for (idx = 0; idx < H_ACTIVE * V_ACTIVE; idx++) begin
            if (hero_x < 0 && frame_buf[idx] == COLOR_CHAR) begin
                hero_x = idx % H_ACTIVE;
                hero_y = idx / H_ACTIVE;
            end
        end
        if (hero_x < 0) begin
            stop_run($sformatf("Test %0d: the hero is not visible in the frame", test_no));
        end else begin
            check_value("hero x", exp_x, hero_x);
            check_value("hero y", exp_y, hero_y);
            for (idx = 0; idx < H_ACTIVE * V_ACTIVE; idx++) begin
                check_value($sformatf("pixel %0d,%0d", idx % H_ACTIVE, idx / H_ACTIVE),
                            int'(scene_colour(idx % H_ACTIVE, idx / H_ACTIVE, exp_x, exp_y)),
                            int'(frame_buf[idx]));
            end
        end
    endtask

    task automatic drive_buttons(input logic l, input logic r, input logic j);
        @(posedge clk);
        step_left  <= l;
        step_right <= r;
        step_jump  <= j;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor sampling on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Counters sit at 0,0 on the first cycle after reset and the ports trail them by three
    always @(negedge clk) begin
        if (rst_n) begin
            cycle = cycle + 1;
            if (cycle >= limit) begin
                stop_run($sformatf("Timeout: the run did not end within %0d cycles", limit));
            end else begin
                oi     = cycle - LATENCY;
                exp_hs = 1;
                exp_vs = 1;
                oh     = H_ACTIVE;
                ov     = V_ACTIVE;
                if (oi >= 0) begin
                    oh = oi % H_TOTAL;
                    ov = (oi / H_TOTAL) % V_TOTAL;
                    if (oh >= H_ACTIVE + H_FRONT && oh < H_ACTIVE + H_FRONT + H_SYNC) begin
                        exp_hs = 0;
                    end
                    if (ov >= V_ACTIVE + V_FRONT && ov < V_ACTIVE + V_FRONT + V_SYNC) begin
                        exp_vs = 0;
                    end
                end
                check_value("hsync", exp_hs, int'(hs));
                check_value("vsync", exp_vs, int'(vs));
                if (oh < H_ACTIVE && ov < V_ACTIVE) begin
                    frame_buf[ov * H_ACTIVE + oh] = rgb;
                end else begin
                    check_value("rgb in blanking", 0, int'(rgb));
                end
                if (vs_last == 1 && vs == 1'b0) begin
                    -> vs_fall_ev;
                end
                vs_last = int'(vs);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_n        = 1'b0;
        step_left    = 1'b0;
        step_right   = 1'b0;
        step_jump    = 1'b0;
        test_no      = 0;
        cycle        = -1;
        vs_last      = 1;
        total_frames = 0;
        limit        = FRAME_CYCLES;
        for (rec = 0; rec < REC_WORDS * MAX_RECS; rec++) begin
            tdata[rec] = 8'hff;
        end
        $readmemh("test/top_vga_testdata.txt", tdata);

        // Every record holds its buttons for some frames and then scans one more
        rec = 0;
        while (rec < MAX_RECS && tdata[rec * REC_WORDS] != 8'hff) begin
            total_frames = total_frames + int'(tdata[rec * REC_WORDS + 4]) + 1;
            rec = rec + 1;
        end
        if (rec == 0) begin
            stop_run("No test records were read from the data file");
        end
        limit = (total_frames + 4) * FRAME_CYCLES;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Line up with the vertical sync so each record starts just before a frame pulse
        @(vs_fall_ev);
        rec = 0;
        while (rec < MAX_RECS && tdata[rec * REC_WORDS] != 8'hff) begin
            base    = rec * REC_WORDS;
            test_no = int'(tdata[base]);
            drive_buttons(tdata[base + 1][0], tdata[base + 2][0], tdata[base + 3][0]);
            repeat (int'(tdata[base + 4])) @(vs_fall_ev);
            drive_buttons(1'b0, 1'b0, 1'b0);
            @(vs_fall_ev);
            check_frame(int'(tdata[base + 5]), int'(tdata[base + 6]));
            rec = rec + 1;
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== test/top_vga_testdata.txt ====
// Columns in hex: test, left, right, jump, frames held, expected x, expected y
// Each record is followed by one idle frame before its frame is scanned
01 0 0 0 00 02 11
// Walking, both directions and clamping at the edges
02 0 1 0 05 07 11
03 1 0 0 03 04 11
04 1 0 0 08 00 11
05 1 1 0 04 00 11
06 0 1 0 20 1d 11
07 1 0 0 13 0a 11
// Jump from the floor, apex six rows up and back after twelve frames
08 0 0 1 01 0a 0f
09 0 0 0 03 0a 0b
0a 0 0 0 05 0a 11
0b 0 0 0 00 0a 11
// Jump to the right onto the platform, walk along it and drop off its end
0c 0 1 1 01 0b 0f
0d 0 1 0 04 0f 0b
0e 0 1 0 0a 19 0b
0f 0 1 0 01 1a 0b
10 0 0 0 06 1a 11
ff 0 0 0 00 00 00

// ==== verilog.f ====
rtl/game_pkg.sv
rtl/vga_timing.sv
rtl/draw_bg.sv
rtl/char_ctrl.sv
rtl/draw_char.sv
rtl/platform_layer.sv
rtl/top_vga.sv
test/top_vga_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/10ps -j 0 \
		--top-module top_vga_tb -f verilog.f -o top_vga_sim
	./obj_dir/top_vga_sim

clean:
	rm -rf obj_dir
